// File: verilog/kyberPkg.sv
// Kyber encryption tail constants
`default_nettype none

package kyberPkg;

  // --------------------------------------------------------------------------
  // Kyber512 ring parameters
  // --------------------------------------------------------------------------
  // Coefficients per polynomial
  parameter int KyberN       = 256;
  // Prime modulus
  parameter int KyberQ       = 3329;
  // Bits needed to hold one value below q
  parameter int CoefWidth    = 12;

  // --------------------------------------------------------------------------
  // Message and ciphertext geometry
  // --------------------------------------------------------------------------
  // 32-byte message, one bit per coefficient
  parameter int MsgBits      = 256;
  // Bits kept per coefficient of v after compression
  parameter int CompressBits = 4;
  // Packed v, one nibble per coefficient
  parameter int CipherVBits  = 1024;
  // (q+1)/2, the value a one bit decodes to
  parameter int MsgOne       = 1665;

  typedef logic [CoefWidth-1:0] coef_t;
  typedef logic [7:0]           coefAddr_t;

endpackage

`default_nettype wire

// File: verilog/coefRam.sv
// Coefficient dual-port memory
`default_nettype none

module coefRam #(
  parameter int Depth = 256,
  parameter int Width = 12
) (
  input  wire                      clk,
  input  wire                      i_wrEn,
  input  wire [$clog2(Depth)-1:0]  i_wrAddr,
  input  wire [Width-1:0]          i_wrData,
  input  wire [$clog2(Depth)-1:0]  i_rdAddr,
  output logic [Width-1:0]         o_rdData
);

  // Storage array, maps onto block RAM
  logic [Width-1:0] mem [Depth];

  // Write port
  always_ff @(posedge clk) begin
    if (i_wrEn) begin
      mem[i_wrAddr] <= i_wrData;
    end
  end

  // Read port, data one cycle after address
  always_ff @(posedge clk) begin
    o_rdData <= mem[i_rdAddr];
  end

endmodule

`default_nettype wire

// File: verilog/msgDecoder.sv
// Message to polynomial decoder
`default_nettype none

module msgDecoder (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          i_enable,
  input  wire [kyberPkg::MsgBits-1:0]  i_msg,
  output logic                         o_wrEn,
  output kyberPkg::coefAddr_t          o_wrAddr,
  output kyberPkg::coef_t              o_wrData,
  output logic                         o_done
);

  localparam kyberPkg::coefAddr_t LastIdx = kyberPkg::coefAddr_t'(kyberPkg::KyberN - 1);

  // Walk state
  logic                active;
  kyberPkg::coefAddr_t idx;

  // Bit index counter, LSB of the message first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      idx    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_enable) begin
        active <= 1'b1;
        idx    <= '0;
      end else if (active) begin
        // Last coefficient written this cycle
        if (idx == LastIdx) begin
          active <= 1'b0;
          o_done <= 1'b1;
        end
        idx <= idx + 1'b1;
      end
    end
  end

  // One write per active cycle
  assign o_wrEn   = active;
  assign o_wrAddr = idx;
  // Bit set decodes to (q+1)/2, bit clear to zero
  assign o_wrData = i_msg[idx] ? kyberPkg::coef_t'(kyberPkg::MsgOne) : '0;

endmodule

`default_nettype wire

// File: verilog/polyAdder.sv
// Modular polynomial adder
`default_nettype none

module polyAdder (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  i_enable,
  input  wire kyberPkg::coef_t i_aData,
  input  wire kyberPkg::coef_t i_bData,
  output kyberPkg::coefAddr_t  o_rdAddr,
  output logic                 o_wrEn,
  output kyberPkg::coefAddr_t  o_wrAddr,
  output kyberPkg::coef_t      o_wrData,
  output logic                 o_done
);

  localparam kyberPkg::coefAddr_t LastIdx = kyberPkg::coefAddr_t'(kyberPkg::KyberN - 1);
  // q widened by one bit to match the raw sum
  localparam logic [kyberPkg::CoefWidth:0] QWide =
    (kyberPkg::CoefWidth + 1)'(kyberPkg::KyberQ);

  // Read stage
  logic                rdActive;
  kyberPkg::coefAddr_t rdCnt;
  logic                rdValid;
  kyberPkg::coefAddr_t rdAddrQ;

  // Add stage
  logic [kyberPkg::CoefWidth:0] sumRaw;
  logic [kyberPkg::CoefWidth:0] sumRed;

  // --------------------------------------------------------------------------
  // Control pipeline
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdActive <= 1'b0;
      rdCnt    <= '0;
      rdValid  <= 1'b0;
      o_wrEn   <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      if (i_enable) begin
        rdActive <= 1'b1;
        rdCnt    <= '0;
      end else if (rdActive) begin
        if (rdCnt == LastIdx) begin
          rdActive <= 1'b0;
        end
        rdCnt <= rdCnt + 1'b1;
      end
      // Follows the RAM read latency
      rdValid <= rdActive;
      o_wrEn  <= rdValid;
      // Done once the final sum has landed
      o_done  <= o_wrEn && (o_wrAddr == LastIdx);
    end
  end

  // Address and data pipeline
  always_ff @(posedge clk) begin
    rdAddrQ  <= rdCnt;
    o_wrAddr <= rdAddrQ;
    o_wrData <= sumRed[kyberPkg::CoefWidth-1:0];
  end

  // Both inputs below q, so one conditional subtract
  assign sumRaw = {1'b0, i_aData} + {1'b0, i_bData};
  assign sumRed = (sumRaw >= QWide) ? (sumRaw - QWide) : sumRaw;

  // Same address feeds both source RAMs
  assign o_rdAddr = rdCnt;

endmodule

`default_nettype wire

// File: verilog/polyCompressor.sv
// 4-bit compressor and packer for v
`default_nettype none

module polyCompressor (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              i_enable,
  input  wire kyberPkg::coef_t             i_rdData,
  output kyberPkg::coefAddr_t              o_rdAddr,
  output logic [kyberPkg::CipherVBits-1:0] o_cipherV,
  output logic                             o_done
);

  localparam kyberPkg::coefAddr_t LastIdx = kyberPkg::coefAddr_t'(kyberPkg::KyberN - 1);
  // Room for 16x + (q-1)/2
  localparam int NumWidth = kyberPkg::CoefWidth + kyberPkg::CompressBits + 1;
  localparam logic [NumWidth-1:0] QNum  = NumWidth'(kyberPkg::KyberQ);
  localparam logic [NumWidth-1:0] HalfQ = NumWidth'((kyberPkg::KyberQ - 1) / 2);

  // Read stage
  logic                rdActive;
  kyberPkg::coefAddr_t rdCnt;
  logic                rdValid;
  kyberPkg::coefAddr_t rdAddrQ;

  // Compress datapath
  logic [NumWidth-1:0]               scaled;
  logic [NumWidth-1:0]               quot;
  logic [kyberPkg::CompressBits-1:0] nibble;
  logic [kyberPkg::CipherVBits-1:0]  packReg;

  // --------------------------------------------------------------------------
  // Read sequencing
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdActive <= 1'b0;
      rdCnt    <= '0;
      rdValid  <= 1'b0;
    end else begin
      if (i_enable) begin
        rdActive <= 1'b1;
        rdCnt    <= '0;
      end else if (rdActive) begin
        if (rdCnt == LastIdx) begin
          rdActive <= 1'b0;
        end
        rdCnt <= rdCnt + 1'b1;
      end
      rdValid <= rdActive;
    end
  end

  // Index of the coefficient now on i_rdData
  always_ff @(posedge clk) begin
    rdAddrQ <= rdCnt;
  end

  // round(16x/q) mod 16
  assign scaled = (NumWidth'(i_rdData) << kyberPkg::CompressBits) + HalfQ;
  assign quot   = scaled / QNum;
  assign nibble = quot[kyberPkg::CompressBits-1:0];

  // --------------------------------------------------------------------------
  // Packing register
  // --------------------------------------------------------------------------
  // Nibble i at bits 4i+3..4i, no shifting
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      packReg <= '0;
    end else if (rdValid) begin
      packReg[rdAddrQ*kyberPkg::CompressBits +: kyberPkg::CompressBits] <= nibble;
    end
  end

  assign o_rdAddr  = rdCnt;
  assign o_cipherV = packReg;
  // High while the last nibble is placed
  assign o_done    = rdValid && (rdAddrQ == LastIdx);

endmodule

`default_nettype wire

// File: verilog/encSequencer.sv
// Encryption step sequencer
`default_nettype none

module encSequencer (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  i_start,
  input  wire  i_decDone,
  input  wire  i_vLoadDone,
  input  wire  i_addDone,
  input  wire  i_compDone,
  output logic o_decEnable,
  output logic o_vLoadEnable,
  output logic o_addEnable,
  output logic o_compEnable,
  output logic o_busy,
  output logic o_encDone
);

  typedef enum logic [2:0] {
    Idle,
    Decode,
    LoadV,
    Add,
    Compress
  } encState_t;

  encState_t state;
  encState_t nextState;

  // --------------------------------------------------------------------------
  // State register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= Idle;
    end else begin
      state <= nextState;
    end
  end

  // Advance on each step's done pulse
  always_comb begin
    nextState = state;
    case (state)
      Idle:     if (i_start)     nextState = Decode;
      Decode:   if (i_decDone)   nextState = LoadV;
      LoadV:    if (i_vLoadDone) nextState = Add;
      Add:      if (i_addDone)   nextState = Compress;
      Compress: if (i_compDone)  nextState = Idle;
      default:                   nextState = Idle;
    endcase
  end

  // --------------------------------------------------------------------------
  // Step enables and done
  // --------------------------------------------------------------------------
  // Pulses fire on the transition pair, low otherwise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_decEnable   <= 1'b0;
      o_vLoadEnable <= 1'b0;
      o_addEnable   <= 1'b0;
      o_compEnable  <= 1'b0;
      o_encDone     <= 1'b0;
    end else begin
      o_decEnable   <= 1'b0;
      o_vLoadEnable <= 1'b0;
      o_addEnable   <= 1'b0;
      o_compEnable  <= 1'b0;
      o_encDone     <= 1'b0;
      case ({state, nextState})
        {Idle, Decode}:    o_decEnable   <= 1'b1;
        // Request V from the INTT side
        {Decode, LoadV}:   o_vLoadEnable <= 1'b1;
        {LoadV, Add}:      o_addEnable   <= 1'b1;
        {Add, Compress}:   o_compEnable  <= 1'b1;
        // Packed v is valid alongside this pulse
        {Compress, Idle}:  o_encDone     <= 1'b1;
        default: ;
      endcase
    end
  end

  // Start pulses are dropped while busy
  assign o_busy = (state != Idle);

endmodule

`default_nettype wire

// File: verilog/kyberEncTail.sv
// Kyber512 encryption tail top
`default_nettype none

module kyberEncTail (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              i_start,
  input  wire [kyberPkg::MsgBits-1:0]      i_msg,
  input  wire                              i_vWrite,
  input  wire kyberPkg::coefAddr_t         i_vAddr,
  input  wire kyberPkg::coef_t             i_vData,
  input  wire                              i_vLoadDone,
  output logic                             o_vLoadEnable,
  output logic                             o_busy,
  output logic                             o_encDone,
  output logic [kyberPkg::CipherVBits-1:0] o_cipherV
);

  // Step handshakes
  logic decEnable;
  logic decDone;
  logic addEnable;
  logic addDone;
  logic compEnable;
  logic compDone;

  // Message RAM ports
  logic                decWrEn;
  kyberPkg::coefAddr_t decWrAddr;
  kyberPkg::coef_t     decWrData;
  kyberPkg::coef_t     msgRdData;

  // Adder ports, one address shared by both sources
  kyberPkg::coefAddr_t addRdAddr;
  kyberPkg::coef_t     vRdData;
  logic                sumWrEn;
  kyberPkg::coefAddr_t sumWrAddr;
  kyberPkg::coef_t     sumWrData;

  // Compressor read port
  kyberPkg::coefAddr_t compRdAddr;
  kyberPkg::coef_t     sumRdData;

  // --------------------------------------------------------------------------
  // Control
  // --------------------------------------------------------------------------
  encSequencer seq0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_start       (i_start),
    .i_decDone     (decDone),
    .i_vLoadDone   (i_vLoadDone),
    .i_addDone     (addDone),
    .i_compDone    (compDone),
    .o_decEnable   (decEnable),
    .o_vLoadEnable (o_vLoadEnable),
    .o_addEnable   (addEnable),
    .o_compEnable  (compEnable),
    .o_busy        (o_busy),
    .o_encDone     (o_encDone)
  );

  // --------------------------------------------------------------------------
  // Datapath steps and coefficient stores
  // --------------------------------------------------------------------------
  msgDecoder dec0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_enable (decEnable),
    .i_msg    (i_msg),
    .o_wrEn   (decWrEn),
    .o_wrAddr (decWrAddr),
    .o_wrData (decWrData),
    .o_done   (decDone)
  );

  coefRam #(.Depth(kyberPkg::KyberN), .Width(kyberPkg::CoefWidth)) msgRam (
    .clk      (clk),
    .i_wrEn   (decWrEn),
    .i_wrAddr (decWrAddr),
    .i_wrData (decWrData),
    .i_rdAddr (addRdAddr),
    .o_rdData (msgRdData)
  );

  // Written straight from the external INTT result port
  coefRam #(.Depth(kyberPkg::KyberN), .Width(kyberPkg::CoefWidth)) vRam (
    .clk      (clk),
    .i_wrEn   (i_vWrite),
    .i_wrAddr (i_vAddr),
    .i_wrData (i_vData),
    .i_rdAddr (addRdAddr),
    .o_rdData (vRdData)
  );

  polyAdder add0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_enable (addEnable),
    .i_aData  (msgRdData),
    .i_bData  (vRdData),
    .o_rdAddr (addRdAddr),
    .o_wrEn   (sumWrEn),
    .o_wrAddr (sumWrAddr),
    .o_wrData (sumWrData),
    .o_done   (addDone)
  );

  coefRam #(.Depth(kyberPkg::KyberN), .Width(kyberPkg::CoefWidth)) sumRam (
    .clk      (clk),
    .i_wrEn   (sumWrEn),
    .i_wrAddr (sumWrAddr),
    .i_wrData (sumWrData),
    .i_rdAddr (compRdAddr),
    .o_rdData (sumRdData)
  );

  polyCompressor comp0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_enable  (compEnable),
    .i_rdData  (sumRdData),
    .o_rdAddr  (compRdAddr),
    .o_cipherV (o_cipherV),
    .o_done    (compDone)
  );

endmodule

`default_nettype wire

// File: bench/tbKyberEnc.sv
// Kyber encryption tail testbench
`default_nettype none

module tbKyberEnc;

  localparam int ClkPeriod    = 100;
  localparam int RunLimit     = 8;
  localparam int CyclesPerRun = 4000;
  localparam int TailCycles   = 1500;

  logic clk = 1'b0;
  logic rst_n;

  // DUT inputs
  logic                                  i_start;
  logic [kyberPkg::MsgBits-1:0]          i_msg;
  logic                                  i_vWrite;
  kyberPkg::coefAddr_t                   i_vAddr;
  kyberPkg::coef_t                       i_vData;
  logic                                  i_vLoadDone;

  // DUT outputs
  logic                                  o_vLoadEnable;
  logic                                  o_busy;
  logic                                  o_encDone;
  logic [kyberPkg::CipherVBits-1:0]      o_cipherV;

  // V polynomial handed to the DUT on each load request
  logic [kyberPkg::KyberN-1:0][kyberPkg::CoefWidth-1:0] vPoly;

  // Expected packed v for each accepted start
  logic [kyberPkg::CipherVBits-1:0] expQ [$];

  // Event counters
  int startCount = 0;
  int vLoadCount = 0;
  int doneCount  = 0;

  kyberEncTail dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_start       (i_start),
    .i_msg         (i_msg),
    .i_vWrite      (i_vWrite),
    .i_vAddr       (i_vAddr),
    .i_vData       (i_vData),
    .i_vLoadDone   (i_vLoadDone),
    .o_vLoadEnable (o_vLoadEnable),
    .o_busy        (o_busy),
    .o_encDone     (o_encDone),
    .o_cipherV     (o_cipherV)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // --------------------------------------------------------------------------
  // Reference model and compare
  // --------------------------------------------------------------------------
  // Decode, add mod q, round(16x/q) mod 16, nibble i at bits 4i+3..4i
  function automatic logic [kyberPkg::CipherVBits-1:0] refCipherV(
    input logic [kyberPkg::MsgBits-1:0]                     msg,
    input logic [kyberPkg::KyberN-1:0][kyberPkg::CoefWidth-1:0] vIn
  );
    logic [kyberPkg::CipherVBits-1:0] res;
    int i;
    int m;
    int s;
    int nib;
    res = '0;
    for (i = 0; i < kyberPkg::KyberN; i++) begin
      m   = msg[i] ? kyberPkg::MsgOne : 0;
      s   = (m + int'(vIn[i])) % kyberPkg::KyberQ;
      // floor(16s/q + 1/2) with no tie since q is odd
      nib = (32 * s + kyberPkg::KyberQ) / (2 * kyberPkg::KyberQ);
      res[i*kyberPkg::CompressBits +: kyberPkg::CompressBits] = 4'(nib % 16);
    end
    return res;
  endfunction

  task automatic checkValue(
    input string                            name,
    input logic [kyberPkg::CipherVBits-1:0] actual,
    input logic [kyberPkg::CipherVBits-1:0] expected
  );
    if (actual !== expected) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, actual, expected);
      $display("Verification failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // --------------------------------------------------------------------------
  // V source answering each load request
  // --------------------------------------------------------------------------
  task automatic loadVPoly();
    int order [kyberPkg::KyberN];
    int i;
    int j;
    int tmp;
    int gap;
    for (i = 0; i < kyberPkg::KyberN; i++) begin
      order[i] = i;
    end
    // Shuffle write order
    for (i = kyberPkg::KyberN - 1; i > 0; i--) begin
      j        = int'($urandom % (i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (i = 0; i < kyberPkg::KyberN; i++) begin
      @(posedge clk);
      i_vWrite <= 1'b1;
      i_vAddr  <= kyberPkg::coefAddr_t'(order[i]);
      i_vData  <= vPoly[order[i]];
      gap = int'($urandom % 3);
      repeat (gap) begin
        @(posedge clk);
        i_vWrite <= 1'b0;
      end
    end
    @(posedge clk);
    i_vWrite    <= 1'b0;
    i_vLoadDone <= 1'b1;
    @(posedge clk);
    i_vLoadDone <= 1'b0;
  endtask

  initial begin : vSource
    i_vWrite    = 1'b0;
    i_vAddr     = '0;
    i_vData     = '0;
    i_vLoadDone = 1'b0;
    forever begin
      @(negedge clk);
      if (o_vLoadEnable) begin
        loadVPoly();
      end
    end
  end

  // --------------------------------------------------------------------------
  // Output monitor
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    if (rst_n) begin
      if (o_vLoadEnable) begin
        vLoadCount++;
      end
      if (o_encDone) begin
        if (expQ.size() == 0) begin
          $display("o_encDone pulsed with no run pending");
          $display("Verification failed");
          $fatal(1, "Unexpected done pulse");
        end else begin
          checkValue("o_cipherV", o_cipherV, expQ.pop_front());
          doneCount++;
        end
      end else if (startCount > doneCount) begin
        // Busy must hold for the whole run
        checkValue("o_busy", 1024'(o_busy), 1024'(1));
      end
    end
  end

  // Hard stop
  initial begin : watchdog
    #(RunLimit * CyclesPerRun * ClkPeriod);
    $display("Timeout, the runs did not finish within the cycle budget");
    $display("Verification failed");
    $fatal(1, "Watchdog expired");
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  task automatic randomMessage(output logic [kyberPkg::MsgBits-1:0] m);
    int k;
    for (k = 0; k < kyberPkg::MsgBits / 32; k++) begin
      m[32*k +: 32] = $urandom;
    end
  endtask

  // One encryption with an optional start pulse while busy
  task automatic runEncrypt(input logic [kyberPkg::MsgBits-1:0] msg, input bit strayStart);
    expQ.push_back(refCipherV(msg, vPoly));
    @(posedge clk);
    i_msg   <= msg;
    i_start <= 1'b1;
    @(posedge clk);
    i_start <= 1'b0;
    startCount++;
    if (strayStart) begin
      while (vLoadCount < startCount) @(posedge clk);
      i_start <= 1'b1;
      @(posedge clk);
      i_start <= 1'b0;
    end
    while (doneCount < startCount) @(posedge clk);
    checkValue("o_vLoadEnable count", 1024'(vLoadCount), 1024'(startCount));
  endtask

  initial begin : stimulus
    logic [kyberPkg::MsgBits-1:0] msg;
    int seedDummy;
    int i;
    int run;
    seedDummy = $urandom(62551);
    rst_n   = 1'b0;
    i_start = 1'b0;
    i_msg   = '0;
    vPoly   = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Reset values
    @(negedge clk);
    checkValue("o_busy", 1024'(o_busy), '0);
    checkValue("o_vLoadEnable", 1024'(o_vLoadEnable), '0);
    checkValue("o_encDone", 1024'(o_encDone), '0);
    checkValue("o_cipherV", o_cipherV, '0);

    // All-zero message and V
    runEncrypt('0, 1'b0);
    checkValue("o_cipherV", o_cipherV, '0);

    // All-ones message where 1665 packs to 8
    runEncrypt('1, 1'b0);
    checkValue("o_cipherV", o_cipherV, {256{4'h8}});

    // Random message and V with a stray start on the middle run
    for (run = 0; run < 3; run++) begin
      randomMessage(msg);
      for (i = 0; i < kyberPkg::KyberN; i++) begin
        vPoly[i] = kyberPkg::coef_t'($urandom % kyberPkg::KyberQ);
      end
      runEncrypt(msg, run == 1);
    end

    // V in [q-1665, q-1] forces the wrap
    for (i = 0; i < kyberPkg::KyberN; i++) begin
      vPoly[i] = kyberPkg::coef_t'(kyberPkg::KyberQ - kyberPkg::MsgOne +
                                   int'($urandom % kyberPkg::MsgOne));
    end
    runEncrypt('1, 1'b0);

    // Nothing further may happen once idle
    repeat (TailCycles) @(posedge clk);
    checkValue("o_vLoadEnable count", 1024'(vLoadCount), 1024'(startCount));
    checkValue("o_busy", 1024'(o_busy), '0);

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
verilog/kyberPkg.sv
verilog/coefRam.sv
verilog/msgDecoder.sv
verilog/polyAdder.sv
verilog/polyCompressor.sv
verilog/encSequencer.sv
verilog/kyberEncTail.sv
bench/tbKyberEnc.sv

// File: Makefile
# Verilator build and run for the Kyber encryption tail testbench

TOP := tbKyberEnc

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	verilator --binary --timing --top-module $(TOP) -f all.f -Mdir obj_dir -o simKyber

# Pass only when the pass line shows up in the output
run: compile
	./obj_dir/simKyber | tee /dev/stderr | grep "Verification passed" > /dev/null

clean:
	rm -rf obj_dir
